/* logic/soc_pkg.sv */
package soc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  be_t;                  // bit n enables byte n

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        be_t   be;
        logic  write;                           // 1 = write, 0 = read
    } bus_req_t;

    typedef logic [1:0] region_t;

    localparam region_t REGION_RAM  = 2'd0;
    localparam region_t REGION_GPIO = 2'd1;
    localparam region_t REGION_NONE = 2'd2;

    // address bits 31..28
    localparam logic [3:0] RAM_BASE_NIBBLE  = 4'h0;
    localparam logic [3:0] GPIO_BASE_NIBBLE = 4'h1;

    // address bits 7..0 inside the gpio window
    localparam logic [7:0] GPIO_OUT_OFS = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS  = 8'h04;

    function automatic word_t be_merge(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* logic/main_ram.sv */
`timescale 1ns/100ps

module main_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         clk_i,
    input  logic                         en_i,
    input  logic                         we_i,
    input  logic [$clog2(RAM_WORDS)-1:0] index_i,
    input  soc_pkg::be_t                 be_i,
    input  soc_pkg::word_t               wdata_i,
    output soc_pkg::word_t               rdata_o
);

    soc_pkg::word_t mem [RAM_WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (be_i[b]) begin
                        mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[index_i];        // data valid one cycle later
            end
        end
    end

endmodule

/* logic/ram_arbiter.sv */
`timescale 1ns/100ps

module ram_arbiter #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              ib_valid_i,
    output logic              ib_ready_o,
    input  soc_pkg::bus_req_t ib_req_i,
    output logic              ib_rsp_valid_o,
    output soc_pkg::word_t    ib_rdata_o,
    input  logic              db_valid_i,
    output logic              db_ready_o,
    input  soc_pkg::bus_req_t db_req_i,
    output logic              db_rsp_valid_o,
    output soc_pkg::word_t    db_rdata_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic              ib_grant;
    logic              db_grant;
    logic              ram_en;
    soc_pkg::bus_req_t win_req;
    logic [IDX_W-1:0]  ram_index;
    soc_pkg::word_t    ram_rdata;
    logic              owner_q;                 // 0 = ibus, 1 = dbus
    logic              rd_pend_q;

    assign ib_grant = ib_valid_i;               // ibus always wins
    assign db_grant = db_valid_i & ~ib_valid_i;
    assign ram_en   = ib_grant | db_grant;

    assign ib_ready_o = 1'b1;
    assign db_ready_o = ~ib_valid_i;

    assign win_req   = ib_grant ? ib_req_i : db_req_i;
    assign ram_index = IDX_W'(win_req.addr[31:2] % RAM_WORDS);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            owner_q   <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            owner_q   <= db_grant;
            rd_pend_q <= ram_en & ~win_req.write;
        end
    end

    main_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_main_ram (
        .clk_i  (clk_i),
        .en_i   (ram_en),
        .we_i   (win_req.write),
        .index_i(ram_index),
        .be_i   (win_req.be),
        .wdata_i(win_req.wdata),
        .rdata_o(ram_rdata)
    );

    // steer the returning word to whoever issued the read
    assign ib_rsp_valid_o = rd_pend_q & ~owner_q;
    assign db_rsp_valid_o = rd_pend_q & owner_q;
    assign ib_rdata_o     = owner_q ? '0 : ram_rdata;
    assign db_rdata_o     = owner_q ? ram_rdata : '0;

endmodule

/* logic/gpio_regs.sv */
`timescale 1ns/100ps

module gpio_regs (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              valid_i,
    input  soc_pkg::bus_req_t req_i,
    output logic              rsp_valid_o,
    output soc_pkg::word_t    rdata_o,
    input  soc_pkg::word_t    gpio_i,
    output soc_pkg::word_t    gpio_o
);

    logic [7:0]     ofs;
    logic           rd_req;
    logic           rsp_q;
    soc_pkg::word_t out_q;
    soc_pkg::word_t rdata_q;

    assign ofs    = req_i.addr[7:0];
    assign rd_req = valid_i & ~req_i.write;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
            rsp_q <= 1'b0;
        end else begin
            rsp_q <= rd_req;
            if (valid_i && req_i.write && ofs == soc_pkg::GPIO_OUT_OFS) begin
                out_q <= soc_pkg::be_merge(out_q, req_i.wdata, req_i.be);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_req) begin
            case (ofs)
                soc_pkg::GPIO_OUT_OFS: rdata_q <= out_q;
                soc_pkg::GPIO_IN_OFS:  rdata_q <= gpio_i;   // sampled at the read
                default:               rdata_q <= '0;
            endcase
        end
    end

    assign rsp_valid_o = rsp_q;
    assign rdata_o     = rdata_q;
    assign gpio_o      = out_q;

endmodule

/* logic/dbus_decode.sv */
`timescale 1ns/100ps

module dbus_decode (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  soc_pkg::bus_req_t req_i,
    output logic              rsp_valid_o,
    output soc_pkg::word_t    rsp_rdata_o,
    output logic              ram_valid_o,
    input  logic              ram_ready_i,
    input  logic              ram_rsp_valid_i,
    input  soc_pkg::word_t    ram_rdata_i,
    output logic              gpio_valid_o,
    input  logic              gpio_rsp_valid_i,
    input  soc_pkg::word_t    gpio_rdata_i
);

    soc_pkg::region_t region;
    logic             hit_ram;
    logic             hit_gpio;
    logic             hit_none;
    logic             none_pend_q;

    always_comb begin
        case (req_i.addr[31:28])
            soc_pkg::RAM_BASE_NIBBLE:  region = soc_pkg::REGION_RAM;
            soc_pkg::GPIO_BASE_NIBBLE: region = soc_pkg::REGION_GPIO;
            default:                   region = soc_pkg::REGION_NONE;
        endcase
    end

    assign hit_ram  = (region == soc_pkg::REGION_RAM);
    assign hit_gpio = (region == soc_pkg::REGION_GPIO);
    assign hit_none = (region == soc_pkg::REGION_NONE);

    assign ram_valid_o  = req_valid_i & hit_ram;
    assign gpio_valid_o = req_valid_i & hit_gpio;

    // only the ram path can stall
    assign req_ready_o = hit_ram ? ram_ready_i : 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            none_pend_q <= 1'b0;
        end else begin
            none_pend_q <= req_valid_i & hit_none & ~req_i.write;
        end
    end

    // sources never overlap, one read accepted per cycle
    assign rsp_valid_o = ram_rsp_valid_i | gpio_rsp_valid_i | none_pend_q;

    always_comb begin
        if (ram_rsp_valid_i) begin
            rsp_rdata_o = ram_rdata_i;
        end else if (gpio_rsp_valid_i) begin
            rsp_rdata_o = gpio_rdata_i;
        end else begin
            rsp_rdata_o = '0;                   // unmapped reads return zero
        end
    end

endmodule

/* logic/soc_bus_top.sv */
`timescale 1ns/100ps

module soc_bus_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              ibus_req_valid_i,
    output logic              ibus_req_ready_o,
    input  soc_pkg::bus_req_t ibus_req_i,
    output logic              ibus_rsp_valid_o,
    output soc_pkg::word_t    ibus_rdata_o,
    input  logic              dbus_req_valid_i,
    output logic              dbus_req_ready_o,
    input  soc_pkg::bus_req_t dbus_req_i,
    output logic              dbus_rsp_valid_o,
    output soc_pkg::word_t    dbus_rdata_o,
    input  soc_pkg::word_t    gpio_i,
    output soc_pkg::word_t    gpio_o
);

    logic           ram_valid;
    logic           ram_ready;
    logic           ram_rsp_valid;
    soc_pkg::word_t ram_rdata;
    logic           gpio_valid;
    logic           gpio_rsp_valid;
    soc_pkg::word_t gpio_rdata;

    dbus_decode u_dbus_decode (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (dbus_req_valid_i),
        .req_ready_o     (dbus_req_ready_o),
        .req_i           (dbus_req_i),
        .rsp_valid_o     (dbus_rsp_valid_o),
        .rsp_rdata_o     (dbus_rdata_o),
        .ram_valid_o     (ram_valid),
        .ram_ready_i     (ram_ready),
        .ram_rsp_valid_i (ram_rsp_valid),
        .ram_rdata_i     (ram_rdata),
        .gpio_valid_o    (gpio_valid),
        .gpio_rsp_valid_i(gpio_rsp_valid),
        .gpio_rdata_i    (gpio_rdata)
    );

    ram_arbiter #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram_arbiter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ib_valid_i    (ibus_req_valid_i),
        .ib_ready_o    (ibus_req_ready_o),
        .ib_req_i      (ibus_req_i),
        .ib_rsp_valid_o(ibus_rsp_valid_o),
        .ib_rdata_o    (ibus_rdata_o),
        .db_valid_i    (ram_valid),
        .db_ready_o    (ram_ready),
        .db_req_i      (dbus_req_i),        // same request the decoder sees
        .db_rsp_valid_o(ram_rsp_valid),
        .db_rdata_o    (ram_rdata)
    );

    gpio_regs u_gpio_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (gpio_valid),
        .req_i      (dbus_req_i),
        .rsp_valid_o(gpio_rsp_valid),
        .rdata_o    (gpio_rdata),
        .gpio_i     (gpio_i),
        .gpio_o     (gpio_o)
    );

endmodule

/* test/soc_bus_assertions.sv */
`timescale 1ns/100ps

module soc_bus_assertions (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              ib_valid_i,
    input logic              ib_ready_i,
    input soc_pkg::bus_req_t ib_req_i,
    input logic              ib_rsp_valid_i,
    input logic              db_valid_i,
    input logic              db_ready_i,
    input soc_pkg::bus_req_t db_req_i,
    input logic              db_rsp_valid_i
);

    logic ib_rd_acc;
    logic db_rd_acc;

    assign ib_rd_acc = ib_valid_i & ib_ready_i & ~ib_req_i.write;   // read taken this edge
    assign db_rd_acc = db_valid_i & db_ready_i & ~db_req_i.write;

    ibus_never_refused: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ib_valid_i |-> ib_ready_i)
        else $error("ibus request was refused by the arbiter");

    // a response only ever appears one cycle after an accepted read, and always then
    ib_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ib_rsp_valid_i == $past(ib_rd_acc))
        else $error("ibus response valid does not follow an accepted read by one cycle");

    db_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        db_rsp_valid_i == $past(db_rd_acc))
        else $error("dbus response valid does not follow an accepted read by one cycle");

    rsp_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ib_rsp_valid_i && db_rsp_valid_i))
        else $error("ibus and dbus response valids are high together");

endmodule

/* test/soc_bus_tb.sv */
`timescale 1ns/100ps

module soc_bus_tb;

    localparam int RAM_WORDS   = 1024;
    localparam int N_WORDS     = 16;
    localparam int N_RAND      = 120;
    localparam int CYCLE_LIMIT = 2 * (3 + 5 * N_WORDS + 40 + N_RAND);

    logic              clk;
    logic              rst_n;
    logic              ib_valid;
    logic              ib_ready;
    soc_pkg::bus_req_t ib_req;
    logic              ib_rsp_valid;
    soc_pkg::word_t    ib_rdata;
    logic              db_valid;
    logic              db_ready;
    soc_pkg::bus_req_t db_req;
    logic              db_rsp_valid;
    soc_pkg::word_t    db_rdata;
    soc_pkg::word_t    gpio_in;
    soc_pkg::word_t    gpio_out;

    soc_pkg::word_t    ram_model [RAM_WORDS];
    soc_pkg::word_t    gpio_model;
    logic [15:0]       lfsr_q;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    soc_bus_top dut0 (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .ibus_req_valid_i(ib_valid),
        .ibus_req_ready_o(ib_ready),
        .ibus_req_i      (ib_req),
        .ibus_rsp_valid_o(ib_rsp_valid),
        .ibus_rdata_o    (ib_rdata),
        .dbus_req_valid_i(db_valid),
        .dbus_req_ready_o(db_ready),
        .dbus_req_i      (db_req),
        .dbus_rsp_valid_o(db_rsp_valid),
        .dbus_rdata_o    (db_rdata),
        .gpio_i          (gpio_in),
        .gpio_o          (gpio_out)
    );

    bind ram_arbiter soc_bus_assertions u_arb_checks (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ib_valid_i    (ib_valid_i),
        .ib_ready_i    (ib_ready_o),
        .ib_req_i      (ib_req_i),
        .ib_rsp_valid_i(ib_rsp_valid_o),
        .db_valid_i    (db_valid_i),
        .db_ready_i    (db_ready_o),
        .db_req_i      (db_req_i),
        .db_rsp_valid_i(db_rsp_valid_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // one step of x^16 + x^14 + x^13 + x^11 + 1 per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic soc_pkg::word_t apply_bytes(input soc_pkg::word_t old_w,
                                                   input soc_pkg::word_t new_w,
                                                   input soc_pkg::be_t be);
        soc_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    function automatic int ram_index(input soc_pkg::addr_t addr);
        return int'(addr >> 2) % RAM_WORDS;     // word address wraps at the depth
    endfunction

    // the ibus has no decoder so every ibus address lands in ram
    function automatic void model_write(input logic dbus, input soc_pkg::addr_t addr,
                                        input soc_pkg::word_t wdata, input soc_pkg::be_t be);
        if (!dbus || addr[31:28] == 4'h0) begin
            ram_model[ram_index(addr)] = apply_bytes(ram_model[ram_index(addr)], wdata, be);
        end else if (addr[31:28] == 4'h1 && addr[7:0] == 8'h00) begin
            gpio_model = apply_bytes(gpio_model, wdata, be);
        end
    endfunction

    function automatic soc_pkg::word_t model_read(input logic dbus, input soc_pkg::addr_t addr);
        if (!dbus || addr[31:28] == 4'h0) return ram_model[ram_index(addr)];
        if (addr[31:28] == 4'h1 && addr[7:0] == 8'h00) return gpio_model;
        if (addr[31:28] == 4'h1 && addr[7:0] == 8'h04) return gpio_in;
        return '0;
    endfunction

    task automatic compare_word(input string test, input soc_pkg::word_t exp,
                                input soc_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", test, exp, act);
        end
    endtask

    // called at a falling edge and returns at the falling edge after acceptance
    task automatic ibus_access(input string test, input logic wr, input soc_pkg::addr_t addr,
                               input soc_pkg::word_t wdata, input soc_pkg::be_t be,
                               output soc_pkg::word_t rdata);
        ib_valid = 1'b1;
        ib_req   = {addr, wdata, be, wr};
        @(posedge clk);
        checks++;
        if (!ib_ready) begin
            errors++;
            $display("[FAIL] %s ibus ready expected 1 actual %0b", test, ib_ready);
        end
        while (!ib_ready) @(posedge clk);
        @(negedge clk);
        rdata = ib_rdata;
        checks++;
        if (ib_rsp_valid !== !wr) begin
            errors++;
            $display("[FAIL] %s ibus rsp_valid expected %0b actual %0b", test, !wr,
                     ib_rsp_valid);
        end
    endtask

    task automatic dbus_access(input string test, input logic wr, input soc_pkg::addr_t addr,
                               input soc_pkg::word_t wdata, input soc_pkg::be_t be,
                               output soc_pkg::word_t rdata, output int waits);
        db_valid = 1'b1;
        db_req   = {addr, wdata, be, wr};
        waits    = 0;
        @(posedge clk);
        while (!db_ready) begin
            waits++;
            @(posedge clk);
        end
        @(negedge clk);
        rdata = db_rdata;
        checks++;
        if (db_rsp_valid !== !wr) begin
            errors++;
            $display("[FAIL] %s dbus rsp_valid expected %0b actual %0b", test, !wr,
                     db_rsp_valid);
        end
    endtask

    task automatic ibus_ram_roundtrip();
        soc_pkg::word_t rd;
        soc_pkg::word_t wd;
        for (int i = 0; i < N_WORDS; i++) begin
            wd = rand_bits(32);
            ibus_access("ibus_ram", 1'b1, soc_pkg::addr_t'(4 * i), wd, 4'hf, rd);
            model_write(1'b0, soc_pkg::addr_t'(4 * i), wd, 4'hf);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            ibus_access("ibus_ram", 1'b0, soc_pkg::addr_t'(4 * i), '0, 4'hf, rd);
            compare_word("ibus_ram", model_read(1'b0, soc_pkg::addr_t'(4 * i)), rd);
        end
        ib_valid = 1'b0;
    endtask

    task automatic dbus_byte_writes();
        soc_pkg::word_t rd;
        soc_pkg::word_t wd;
        soc_pkg::addr_t a;
        soc_pkg::be_t   be;
        int             waits;
        for (int i = 0; i < N_WORDS; i++) begin
            a  = soc_pkg::addr_t'(4 * (RAM_WORDS + i));     // aliases word i
            wd = rand_bits(32);
            be = 4'(rand_bits(4));
            dbus_access("dbus_shared", 1'b0, a, '0, 4'hf, rd, waits);
            compare_word("dbus_shared", model_read(1'b1, a), rd);
            dbus_access("dbus_bytes", 1'b1, a, wd, be, rd, waits);
            model_write(1'b1, a, wd, be);
            dbus_access("dbus_bytes", 1'b0, soc_pkg::addr_t'(4 * i), '0, 4'hf, rd, waits);
            compare_word("dbus_bytes", model_read(1'b1, soc_pkg::addr_t'(4 * i)), rd);
        end
        db_valid = 1'b0;
    endtask

    task automatic gpio_register_access();
        soc_pkg::word_t rd;
        int             waits;
        gpio_in = rand_bits(32);
        dbus_access("gpio_out", 1'b1, 32'h1000_0000, 32'h1234_5678, 4'hf, rd, waits);
        model_write(1'b1, 32'h1000_0000, 32'h1234_5678, 4'hf);
        compare_word("gpio_out", gpio_model, gpio_out);
        dbus_access("gpio_be", 1'b1, 32'h1000_0000, 32'hdead_beef, 4'b0101, rd, waits);
        model_write(1'b1, 32'h1000_0000, 32'hdead_beef, 4'b0101);
        compare_word("gpio_be", gpio_model, gpio_out);
        dbus_access("gpio_rd_out", 1'b0, 32'h1000_0000, '0, 4'hf, rd, waits);
        compare_word("gpio_rd_out", gpio_model, rd);
        dbus_access("gpio_rd_in", 1'b0, 32'h1000_0004, '0, 4'hf, rd, waits);
        compare_word("gpio_rd_in", gpio_in, rd);
        db_valid = 1'b0;
    endtask

    task automatic unmapped_region();
        soc_pkg::word_t rd;
        int             waits;
        dbus_access("unmapped_rd", 1'b0, 32'h2000_0010, '0, 4'hf, rd, waits);
        compare_word("unmapped_rd", 32'h0, rd);
        dbus_access("unmapped_wr", 1'b1, 32'h3000_0000, 32'hffff_ffff, 4'hf, rd, waits);
        compare_word("unmapped_gpio", gpio_model, gpio_out);
        dbus_access("unmapped_ram", 1'b0, 32'h0000_0000, '0, 4'hf, rd, waits);
        compare_word("unmapped_ram", model_read(1'b1, 32'h0000_0000), rd);
        db_valid = 1'b0;
    endtask

    task automatic bus_contention();
        soc_pkg::word_t rd_i;
        soc_pkg::word_t rd_d;
        int             waits;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    ibus_access("contend_ibus", 1'b0, soc_pkg::addr_t'(4 * i), '0, 4'hf, rd_i);
                    compare_word("contend_ibus", model_read(1'b0, soc_pkg::addr_t'(4 * i)), rd_i);
                end
                ib_valid = 1'b0;
            end
            begin
                dbus_access("contend_dbus", 1'b0, 32'h0000_0020, '0, 4'hf, rd_d, waits);
                compare_word("contend_dbus", model_read(1'b1, 32'h0000_0020), rd_d);
                compare_word("contend_wait", 32'd4, waits);     // held off while ibus is valid
                db_valid = 1'b0;
            end
        join
    endtask

    task automatic random_traffic();
        soc_pkg::word_t rd;
        soc_pkg::word_t wd;
        soc_pkg::addr_t a;
        soc_pkg::be_t   be;
        logic           wr;
        logic           use_db;
        int             waits;
        for (int n = 0; n < N_RAND; n++) begin
            use_db  = 1'(rand_bits(1));
            wr      = 1'(rand_bits(1));
            wd      = rand_bits(32);
            be      = 4'(rand_bits(4));
            gpio_in = rand_bits(32);
            a = soc_pkg::addr_t'(4 * (RAM_WORDS * int'(rand_bits(3)) + int'(rand_bits(4))));
            if (use_db && rand_bits(1) == 32'd1) begin
                a = (rand_bits(1) == 32'd1) ? 32'h1000_0004 : 32'h1000_0000;
            end
            if (use_db) begin
                ib_valid = 1'b0;
                dbus_access("random_dbus", wr, a, wd, be, rd, waits);
                if (!wr) compare_word("random_dbus", model_read(1'b1, a), rd);
                if (wr) model_write(1'b1, a, wd, be);
            end else begin
                db_valid = 1'b0;
                ibus_access("random_ibus", wr, a, wd, be, rd);
                if (!wr) compare_word("random_ibus", model_read(1'b0, a), rd);
                if (wr) model_write(1'b0, a, wd, be);
            end
        end
        ib_valid = 1'b0;
        db_valid = 1'b0;
        compare_word("random_gpio", gpio_model, gpio_out);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        ib_valid   = 1'b0;
        ib_req     = '0;
        db_valid   = 1'b0;
        db_req     = '0;
        gpio_in    = '0;
        gpio_model = '0;
        lfsr_q     = 16'd16812;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        compare_word("reset_gpio", 32'h0, gpio_out);
        ibus_ram_roundtrip();
        dbus_byte_writes();
        gpio_register_access();
        unmapped_region();
        bus_contention();
        random_traffic();
        @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/soc_pkg.sv
logic/main_ram.sv
logic/ram_arbiter.sv
logic/gpio_regs.sv
logic/dbus_decode.sv
logic/soc_bus_top.sv
test/soc_bus_assertions.sv
test/soc_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --sv --assert --timing
TOP       := soc_bus_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the pipeline status is grep's, so a missing pass line fails the target
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
